//--- hw/flitEgress.sv
`timescale 1ns/1ps

module flitEgress
  import nocFlitPkg::*, nocBusPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] grant,
  input  logic [NumPorts-1:0] notEmpty,
  input  flitT                headFlits [NumPorts],
  output wbReqT               busReq,
  input  wbRspT               busRsp,
  output logic [NumPorts-1:0] pop,
  output logic                sent,
  output logic                sentLast
);

  portIdT selPort;
  logic   selReady;

  // One-hot grant to port index
  always_comb
  begin
    selPort = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant[p])
        selPort = portIdT'(p);
    end
  end

  assign selReady = |(grant & notEmpty);

  //////////////////////////////////////////////////
  // Bus master

  always_ff @(posedge clk)
  begin
    // Payload loads at cycle start and holds until the response
    if (!busReq.stb && selReady)
    begin
      busReq.adr <= selPort;
      busReq.dat <= headFlits[selPort];
    end

    if (rst)
    begin
      busReq.cyc <= 1'b0;
      busReq.stb <= 1'b0;
    end
    else if (busReq.stb)
    begin
      if (busRsp.ack || busRsp.err)  // err drops the cycle, flit is retried
      begin
        busReq.cyc <= 1'b0;
        busReq.stb <= 1'b0;
      end
    end
    else if (selReady)
    begin
      busReq.cyc <= 1'b1;
      busReq.stb <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Completion

  assign sent = busReq.stb && busRsp.ack;
  assign pop = sent ? (NumPorts'(1) << busReq.adr) : '0;
  assign sentLast = sent && (busReq.dat.kind == tailFlit ||
                             (busReq.dat.kind == headFlit && busReq.dat.len == 12'd1));

endmodule

//--- hw/flitIngress.sv
`timescale 1ns/1ps

module flitIngress
  import nocFlitPkg::*, nocBusPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  wbReqT               busReq,
  output wbRspT               busRsp,
  input  logic [NumPorts-1:0] full,
  output logic [NumPorts-1:0] pushEn,
  output flitT                pushFlit
);

  logic reqLive;
  logic adrOk;
  logic portFull;

  // Ignore the request in the response cycle
  assign reqLive = busReq.cyc && busReq.stb && !busRsp.ack && !busRsp.err;
  assign adrOk = (busReq.adr < portIdT'(NumPorts));
  assign portFull = adrOk ? full[busReq.adr] : 1'b0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busRsp <= '0;
      pushEn <= '0;
    end
    else
    begin
      busRsp <= '0;
      pushEn <= '0;
      if (reqLive && !adrOk)
        busRsp.err <= 1'b1;  // No such port
      else if (reqLive && !portFull)
      begin
        busRsp.ack <= 1'b1;
        pushEn <= NumPorts'(1) << busReq.adr;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reqLive)
      pushFlit <= busReq.dat;
  end

  // Responses are lone pulses, never both at once
  rspPulse: assert property (@(posedge clk) disable iff (rst)
    (busRsp.ack || busRsp.err) |-> !(busRsp.ack && busRsp.err) ##1 !(busRsp.ack || busRsp.err));

endmodule

//--- hw/nocBusPkg.sv
package nocBusPkg;

  //////////////////////////////////////////////////
  // Wishbone classic, write-only buses

  // Master side
  typedef struct packed {
    logic               cyc;
    logic               stb;
    nocFlitPkg::portIdT adr;  // Input port of the flit
    nocFlitPkg::flitT   dat;
  } wbReqT;

  // Slave side, single-cycle pulses
  typedef struct packed {
    logic ack;
    logic err;
  } wbRspT;

endpackage

//--- hw/nocFlitPkg.sv
package nocFlitPkg;

  //////////////////////////////////////////////////
  // Router ports

  localparam int NumPorts = 5;

  typedef logic [2:0] portIdT;

  localparam portIdT PortLocal = 3'd0;
  localparam portIdT PortNorth = 3'd1;
  localparam portIdT PortEast  = 3'd2;
  localparam portIdT PortWest  = 3'd3;
  localparam portIdT PortSouth = 3'd4;

  //////////////////////////////////////////////////
  // Flit format

  typedef enum logic [2:0] {
    headFlit = 3'd1,
    bodyFlit = 3'd2,
    tailFlit = 3'd3
  } flitKindT;

  // len counts the header too, valid on head flits only
  typedef struct packed {
    flitKindT    kind;
    logic [11:0] len;
    logic [16:0] payload;
  } flitT;

endpackage

//--- hw/packetArbiter.sv
`timescale 1ns/1ps

module packetArbiter
  import nocFlitPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic [NumPorts-1:0] req,
  input  flitT                headFlits [NumPorts],
  input  logic                sent,
  input  logic                sentLast,
  output logic [NumPorts-1:0] grant
);

  portIdT      owner;      // Current or last owner
  logic [11:0] remaining;  // Flits left in the granted packet
  portIdT      pick;
  logic        found;
  logic        lastFlit;

  function automatic portIdT wrapPort(input portIdT base, input int step);
    int sum;
    sum = int'(base) + step;
    if (sum >= NumPorts)
      sum = sum - NumPorts;
    return portIdT'(sum);
  endfunction

  //////////////////////////////////////////////////
  // Rotating priority, starting after the owner

  always_comb
  begin
    found = 1'b0;
    pick = owner;
    for (int i = 1; i <= NumPorts; i++)
    begin
      if (!found && req[wrapPort(owner, i)])
      begin
        found = 1'b1;
        pick = wrapPort(owner, i);
      end
    end
  end

  assign lastFlit = (remaining <= 12'd1);

  //////////////////////////////////////////////////
  // Grant held for a whole packet

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      grant <= '0;
      owner <= PortSouth;  // Local goes first
      remaining <= '0;
    end
    else if (grant == '0)
    begin
      if (found)
      begin
        grant <= NumPorts'(1) << pick;
        owner <= pick;
        remaining <= headFlits[pick].len;
      end
    end
    else if (sent)
    begin
      remaining <= remaining - 1'b1;
      if (lastFlit)
        grant <= '0;
      // An empty queue keeps its grant until the tail arrives
    end
  end

  // Length count and flit kinds must agree on the packet end
  countMatchesTail: assert property (@(posedge clk) disable iff (rst)
    sent |-> (sentLast == lastFlit));

  grantOnHead: assert property (@(posedge clk) disable iff (rst)
    (grant == '0) ##1 (grant != '0) |-> (headFlits[owner].kind == headFlit));

endmodule

//--- hw/portQueue.sv
`timescale 1ns/1ps

module portQueue
  import nocFlitPkg::*;
#(
  parameter int QueueDepth = 4
)
(
  input  logic clk,
  input  logic rst,
  input  logic push,
  input  logic pop,
  input  flitT inFlit,
  output flitT headFlit,
  output logic notEmpty,
  output logic full
);

  localparam int PtrW = $clog2(QueueDepth);

  // Pointers wrap on their own, so depth must be a power of two
  if (QueueDepth < 2 || (QueueDepth & (QueueDepth - 1)) != 0)
  begin : genDepthCheck
    $error("portQueue: QueueDepth must be a power of two of 2 or more");
  end

  flitT            mem [QueueDepth];
  logic [PtrW-1:0] rdPtr;
  logic [PtrW-1:0] wrPtr;
  logic [PtrW:0]   count;

  //////////////////////////////////////////////////
  // Storage

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wrPtr] <= inFlit;
  end

  assign headFlit = mem[rdPtr];

  //////////////////////////////////////////////////
  // Pointers and occupancy

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop together
      endcase
    end
  end

  assign notEmpty = (count != '0);
  assign full = (count == (PtrW + 1)'(QueueDepth));

  noOverflow: assert property (@(posedge clk) disable iff (rst)
    (push && full) |-> pop);

  noUnderflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> notEmpty);

endmodule

//--- hw/routerOutput.sv
`timescale 1ns/1ps

module routerOutput
  import nocFlitPkg::*, nocBusPkg::*;
#(
  parameter int QueueDepth = 4
)
(
  input  logic  clk,
  input  logic  rst,
  input  wbReqT inBusReq,
  output wbRspT inBusRsp,
  output wbReqT outBusReq,
  input  wbRspT outBusRsp
);

  flitT                pushFlit;
  logic [NumPorts-1:0] pushEn;
  logic [NumPorts-1:0] full;
  logic [NumPorts-1:0] notEmpty;
  flitT                headFlits [NumPorts];
  logic [NumPorts-1:0] grant;
  logic [NumPorts-1:0] pop;
  logic                sent;
  logic                sentLast;

  //////////////////////////////////////////////////
  // Input side

  flitIngress flitIngress_i (
    .clk      (clk),
    .rst      (rst),
    .busReq   (inBusReq),
    .busRsp   (inBusRsp),
    .full     (full),
    .pushEn   (pushEn),
    .pushFlit (pushFlit)
  );

  // One queue per input port, L N E W S
  for (genvar p = 0; p < NumPorts; p++)
  begin : genQueue
    portQueue #(
      .QueueDepth (QueueDepth)
    ) portQueue_i (
      .clk      (clk),
      .rst      (rst),
      .push     (pushEn[p]),
      .pop      (pop[p]),
      .inFlit   (pushFlit),
      .headFlit (headFlits[p]),
      .notEmpty (notEmpty[p]),
      .full     (full[p])
    );
  end

  //////////////////////////////////////////////////
  // Output side

  packetArbiter packetArbiter_i (
    .clk       (clk),
    .rst       (rst),
    .req       (notEmpty),
    .headFlits (headFlits),
    .sent      (sent),
    .sentLast  (sentLast),
    .grant     (grant)
  );

  flitEgress flitEgress_i (
    .clk       (clk),
    .rst       (rst),
    .grant     (grant),
    .notEmpty  (notEmpty),
    .headFlits (headFlits),
    .busReq    (outBusReq),
    .busRsp    (outBusRsp),
    .pop       (pop),
    .sent      (sent),
    .sentLast  (sentLast)
  );

endmodule

//--- project.f
hw/nocFlitPkg.sv
hw/nocBusPkg.sv
hw/flitIngress.sv
hw/portQueue.sv
hw/packetArbiter.sv
hw/flitEgress.sv
hw/routerOutput.sv
sim/tbClock.sv
sim/routerChecker.sv
sim/routerOutputTb.sv

//--- sim/routerChecker.sv
`timescale 1ns/1ps

module routerChecker
  import nocFlitPkg::*, nocBusPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  wbReqT  inBusReq,
  input  wbRspT  inBusRsp,
  input  wbReqT  outBusReq,
  input  wbRspT  outBusRsp,
  output int     errCount,
  output int     pendingCount,
  output int     headCount,
  output portIdT lastHead
);

  localparam int ModelDepth = 512;

  flitT  expMem [NumPorts][ModelDepth];  // Acknowledged input flits per port
  int    wrIdx [NumPorts];
  int    rdIdx [NumPorts];
  logic  pktOpen;
  portIdT pktPort;
  wbReqT prevReq;
  logic  prevAck;
  flitT  expFlit;
  flitT  gotFlit;
  int    pending;

  initial
  begin
    errCount = 0;
    pendingCount = 0;
    headCount = 0;
    lastHead = '0;
    pktOpen = 1'b0;
    pktPort = '0;
    prevReq = '0;
    prevAck = 1'b0;
    for (int p = 0; p < NumPorts; p++)
    begin
      wrIdx[p] = 0;
      rdIdx[p] = 0;
    end
  end

  task automatic compareField(input string name, input int got, input int exp);
    if (got != exp)
    begin
      $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      errCount++;
    end
  endtask

  //////////////////////////////////////////////////
  // Model update and comparison, at the falling edge

  always @(negedge clk)
  begin
    if (!rst)
    begin
      if (inBusRsp.ack)
      begin
        expMem[inBusReq.adr][wrIdx[inBusReq.adr] % ModelDepth] = inBusReq.dat;
        wrIdx[inBusReq.adr]++;
      end

      if (outBusReq.stb && outBusRsp.ack)
      begin
        gotFlit = outBusReq.dat;
        if (outBusReq.adr >= portIdT'(NumPorts))
        begin
          $display("Output transfer carries port %0d, which does not exist", outBusReq.adr);
          errCount++;
        end
        else if (rdIdx[outBusReq.adr] == wrIdx[outBusReq.adr])
        begin
          $display("Output flit for port %0d was never written at the input", outBusReq.adr);
          errCount++;
        end
        else
        begin
          expFlit = expMem[outBusReq.adr][rdIdx[outBusReq.adr] % ModelDepth];
          rdIdx[outBusReq.adr]++;
          compareField("outBusReq.dat.kind", int'(gotFlit.kind), int'(expFlit.kind));
          compareField("outBusReq.dat.len", int'(gotFlit.len), int'(expFlit.len));
          compareField("outBusReq.dat.payload", int'(gotFlit.payload), int'(expFlit.payload));
        end

        // Packets must not interleave
        if (pktOpen)
          compareField("outBusReq.adr", int'(outBusReq.adr), int'(pktPort));
        else
        begin
          if (gotFlit.kind != headFlit)
          begin
            $display("Output packet on port %0d does not start with a head flit",
                     outBusReq.adr);
            errCount++;
          end
          headCount++;
          lastHead = outBusReq.adr;
          pktPort = outBusReq.adr;
          pktOpen = 1'b1;
        end
        if (gotFlit.kind == tailFlit || (gotFlit.kind == headFlit && gotFlit.len == 12'd1))
          pktOpen = 1'b0;
      end

      // A strobe is only valid inside a bus cycle
      if (outBusReq.stb && !outBusReq.cyc)
      begin
        $display("Output stb is high at %0t while cyc is low", $time);
        errCount++;
      end
      if (prevReq.stb && !outBusReq.stb && !prevAck)
      begin
        $display("Output stb fell at %0t without an ack", $time);
        errCount++;
      end
      if (prevReq.stb && outBusReq.stb && !prevAck && (prevReq != outBusReq))
      begin
        $display("Output request changed at %0t while waiting for an ack", $time);
        errCount++;
      end
      prevReq = outBusReq;
      prevAck = outBusRsp.ack;

      pending = 0;
      for (int p = 0; p < NumPorts; p++)
        pending += wrIdx[p] - rdIdx[p];
      pendingCount = pending;
    end
  end

endmodule

//--- sim/routerOutputTb.sv
`timescale 1ns/1ps

module routerOutputTb
  import nocFlitPkg::*, nocBusPkg::*;
();

  localparam int QueueDepth = 4;
  localparam int RandPackets = 40;
  localparam int FlitBudget = RandPackets * 6 + 40;
  localparam int CycleLimit = 40 * FlitBudget + 200;

  logic   clk;
  logic   rst;
  wbReqT  inBusReq;
  wbRspT  inBusRsp;
  wbReqT  outBusReq;
  wbRspT  outBusRsp;
  int     errCount;
  int     pendingCount;
  int     headCount;
  portIdT lastHead;
  int     tbErrors;
  logic   holdAck;
  logic [15:0] lfsr;
  logic   gotErr;
  logic   fifthDone;
  flitT   pkt [QueueDepth + 2];
  portIdT rotOrder [7];
  int     baseHeads;

  tbClock tbClock_i (.clk(clk), .rst(rst));

  routerOutput #(.QueueDepth(QueueDepth)) routerOutput_i (
    .clk       (clk),
    .rst       (rst),
    .inBusReq  (inBusReq),
    .inBusRsp  (inBusRsp),
    .outBusReq (outBusReq),
    .outBusRsp (outBusRsp)
  );

  routerChecker routerChecker_i (
    .clk          (clk),
    .rst          (rst),
    .inBusReq     (inBusReq),
    .inBusRsp     (inBusRsp),
    .outBusReq    (outBusReq),
    .outBusRsp    (outBusRsp),
    .errCount     (errCount),
    .pendingCount (pendingCount),
    .headCount    (headCount),
    .lastHead     (lastHead)
  );

  // Galois LFSR, one step per bit
  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic flitT makeFlit(input int idx, input int len);
    flitT f;
    f.kind = (idx == 0) ? headFlit : ((idx == len - 1) ? tailFlit : bodyFlit);
    f.len = (idx == 0) ? 12'(len) : 12'd0;
    f.payload = randBits(17);
    return f;
  endfunction

  //////////////////////////////////////////////////
  // Input master and output slave

  task automatic writeFlit(input portIdT adr, input flitT dat, output logic err);
    @(posedge clk);
    inBusReq.cyc <= 1'b1;
    inBusReq.stb <= 1'b1;
    inBusReq.adr <= adr;
    inBusReq.dat <= dat;
    do
      @(negedge clk);
    while (!(inBusRsp.ack || inBusRsp.err));
    err = inBusRsp.err;
    @(posedge clk);
    inBusReq.cyc <= 1'b0;
    inBusReq.stb <= 1'b0;
  endtask

  task automatic sendPacket(input portIdT port, input int len);
    logic err;
    for (int i = 0; i < len; i++)
    begin
      writeFlit(port, makeFlit(i, len), err);
      if (err)
      begin
        $display("Write to port %0d got err instead of ack", port);
        tbErrors++;
      end
    end
  endtask

  task automatic waitDrained();
    do
    begin
      @(negedge clk);
      #1;
    end
    while (pendingCount != 0 || outBusReq.stb);
  endtask

  initial
  begin
    int delay;
    outBusRsp = '0;
    forever
    begin
      @(negedge clk);
      if (!rst && outBusReq.stb && !holdAck)
      begin
        delay = randBits(2);  // 0 to 3 wait cycles
        repeat (delay) @(posedge clk);
        @(posedge clk);
        outBusRsp.ack <= 1'b1;
        @(posedge clk);
        outBusRsp.ack <= 1'b0;
      end
    end
  end

  initial
  begin
    repeat (CycleLimit) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run did not finish", CycleLimit);
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence

  initial
  begin
    inBusReq = '0;
    holdAck = 1'b0;
    tbErrors = 0;
    lfsr = 16'd16;
    rotOrder = '{PortLocal, PortNorth, PortEast, PortWest, PortSouth, PortNorth, PortSouth};
    @(negedge rst);

    // Rotation, second round queued behind the first
    holdAck = 1'b1;
    for (int p = 0; p < NumPorts; p++)
      sendPacket(portIdT'(p), 2);
    sendPacket(PortSouth, 2);
    sendPacket(PortNorth, 2);
    baseHeads = headCount;
    holdAck = 1'b0;
    for (int i = 0; i < 7; i++)
    begin
      do
      begin
        @(negedge clk);
        #1;
      end
      while (headCount <= baseHeads + i);
      if (lastHead != rotOrder[i])
      begin
        $display("ERROR t=%0t lastHead got %0d expected %0d", $time, lastHead, rotOrder[i]);
        tbErrors++;
      end
    end
    waitDrained();

    // Back-pressure on one queue
    holdAck = 1'b1;
    fifthDone = 1'b0;
    for (int i = 0; i < QueueDepth + 2; i++)
      pkt[i] = makeFlit(i, QueueDepth + 2);
    for (int i = 0; i < QueueDepth; i++)
      writeFlit(PortEast, pkt[i], gotErr);
    fork
      begin
        writeFlit(PortEast, pkt[QueueDepth], gotErr);
        fifthDone = 1'b1;
      end
      begin
        repeat (20) @(negedge clk);
        if (fifthDone)
        begin
          $display("Write to a full queue was acknowledged");
          tbErrors++;
        end
        holdAck = 1'b0;
      end
    join
    writeFlit(PortEast, pkt[QueueDepth + 1], gotErr);
    waitDrained();

    // Addresses past the last port
    for (int a = NumPorts; a < 8; a++)
    begin
      writeFlit(portIdT'(a), makeFlit(0, 1), gotErr);
      if (!gotErr)
      begin
        $display("Write to port %0d was not answered with err", a);
        tbErrors++;
      end
    end

    // Random packets, whole packets interleaved across ports
    for (int n = 0; n < RandPackets; n++)
      sendPacket(portIdT'(randBits(3) % NumPorts), int'(randBits(3) % 6) + 1);
    waitDrained();
    repeat (10) @(posedge clk);

    $display("Checker errors %0d, testbench errors %0d, flits pending %0d",
             errCount, tbErrors, pendingCount);
    if (errCount == 0 && tbErrors == 0 && pendingCount == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- sim/tbClock.sv
`timescale 1ns/1ps

module tbClock
(
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial
  begin
    rst = 1'b1;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
  end

endmodule
